// ==== verilog/cc_stream_pkg.sv ====
// Stream payload types and frame sizes, imported by the buffers, the frame builder and the testbench
`default_nettype none

package cc_stream_pkg;

    // Width of one real sample on the input stream
    localparam int SAMPLE_W = 32;

    // Real samples per frame; the padded frame is twice as long
    localparam int FRAME_LEN = 8;

    // Beat counter must hold 2 * FRAME_LEN itself, not only up to it
    localparam int BEAT_CNT_W = $clog2(2 * FRAME_LEN + 1);

    // Buffer depths for the sample ring and the output skid
    localparam int IN_FIFO_DEPTH  = 8;
    localparam int OUT_FIFO_DEPTH = 4;

    // Raw sample as it arrives from the source
    typedef struct packed {
        logic [SAMPLE_W-1:0] data;
    } sample_t;

    // Beat towards the FFT input port
    typedef struct packed {
        logic [SAMPLE_W-1:0] data;
        logic                last;
    } axis_beat_t;

endpackage

`default_nettype wire

// ==== verilog/cc_ctrl_pkg.sv ====
// Control encodings and the fixed FFT configuration, imported by the controllers and the top level
`default_nettype none

package cc_ctrl_pkg;

    // Where the zero half goes in a frame
    typedef enum logic {
        PAD_FRONT = 1'b0,
        PAD_BACK  = 1'b1
    } pad_mode_t;

    // Frame builder states
    typedef enum logic [2:0] {
        IDLE        = 3'd0,
        WAIT_CONFIG = 3'd1,
        FIRST_HALF  = 3'd2,
        SECOND_HALF = 3'd3
    } cc_state_t;

    localparam int CONFIG_W = 16;

    // Bit 0 selects forward transform
    localparam logic CONFIG_FWD = 1'b1;

    // Two bits per radix-4 stage, scale by 2 in each
    localparam logic [9:0] CONFIG_SCALE = 10'b10_10_10_10_10;

    // Upper bits are reserved and kept at zero
    localparam logic [CONFIG_W-1:0] CONFIG_WORD = {5'b0, CONFIG_SCALE, CONFIG_FWD};

endpackage

`default_nettype wire

// ==== verilog/stream_fifo.sv ====
// Valid/ready FIFO with a typed payload, used as the sample ring and as the output skid buffer
`default_nettype none

module stream_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     reset_b,

    // Write side
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    // Read side
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic push;
    logic pop;

    // Ready depends only on occupancy, never on out_ready
    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Pointers wrap explicitly so any depth works
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            wr_ptr <= '0;
        end else if (push) begin
            if (wr_ptr == PTR_W'(DEPTH - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            rd_ptr <= '0;
        end else if (pop) begin
            if (rd_ptr == PTR_W'(DEPTH - 1)) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy, unchanged on a simultaneous push and pop
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fft_config_ctrl.sv ====
// Sends the fixed configuration word to the FFT once after reset and flags completion
`default_nettype none

module fft_config_ctrl import cc_ctrl_pkg::*; (
    input  logic                clk,
    input  logic                reset_b,

    output logic                config_valid,
    input  logic                config_ready,
    output logic [CONFIG_W-1:0] config_data,

    output logic                config_done
);

    typedef enum logic {
        SEND = 1'b0,
        DONE = 1'b1
    } cfg_state_t;

    cfg_state_t state;
    logic       xfer;

    assign xfer = config_valid && config_ready;

    // Word is only meaningful while sending
    assign config_data = (state == SEND) ? CONFIG_WORD : '0;
    assign config_done = (state == DONE);

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state <= SEND;
        end else if (xfer) begin
            state <= DONE;
        end
    end

    // Valid is registered so it stays low during reset and rises one edge later
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            config_valid <= 1'b0;
        end else begin
            config_valid <= (state == SEND) && !xfer;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cc_block_controller.sv ====
// Builds one zero-padded frame per start pulse from buffered samples, marking the final beat
`default_nettype none

module cc_block_controller import cc_stream_pkg::*, cc_ctrl_pkg::*; #(
    parameter pad_mode_t PAD = PAD_BACK
) (
    input  logic       clk,
    input  logic       reset_b,

    input  logic       start,
    input  logic       config_done,

    // Samples from the input FIFO
    input  logic       smp_valid,
    output logic       smp_ready,
    input  sample_t    smp,

    // Beats towards the output FIFO
    output logic       beat_valid,
    input  logic       beat_ready,
    output axis_beat_t beat
);

    cc_state_t state;
    cc_state_t state_next;

    // Beats loaded into the beat register in this frame
    logic [BEAT_CNT_W-1:0] beat_cnt;

    logic       data_half;
    logic       gen_active;
    logic       slot_free;
    logic       load;
    logic       beat_xfer;
    axis_beat_t beat_next;

    // Data goes in the first half for back padding, in the second for front padding
    assign data_half = (state == FIRST_HALF) ? (PAD == PAD_BACK) : (PAD == PAD_FRONT);

    // Second half stops generating once the last beat is loaded
    assign gen_active = (state == FIRST_HALF) ||
                        ((state == SECOND_HALF) && (beat_cnt != BEAT_CNT_W'(2 * FRAME_LEN)));

    // Register can take a new beat when empty or being drained
    assign slot_free = !beat_valid || beat_ready;

    // A data beat needs a sample; a zero beat does not
    assign load      = gen_active && slot_free && (!data_half || smp_valid);
    assign smp_ready = gen_active && slot_free && data_half;
    assign beat_xfer = beat_valid && beat_ready;

    always_comb begin
        beat_next.data = data_half ? smp.data : '0;
        beat_next.last = (beat_cnt == BEAT_CNT_W'(2 * FRAME_LEN - 1));
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = config_done ? FIRST_HALF : WAIT_CONFIG;
                end
            end
            WAIT_CONFIG: begin
                if (config_done) begin
                    state_next = FIRST_HALF;
                end
            end
            FIRST_HALF: begin
                if (load && (beat_cnt == BEAT_CNT_W'(FRAME_LEN - 1))) begin
                    state_next = SECOND_HALF;
                end
            end
            SECOND_HALF: begin
                // Frame ends when the marked beat leaves the register
                if (beat_xfer && beat.last) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            beat_cnt <= '0;
        end else if (load) begin
            beat_cnt <= beat_cnt + 1'b1;
        end else if (state == IDLE) begin
            beat_cnt <= '0;
        end
    end

    // Beat register valid flag
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            beat_valid <= 1'b0;
        end else if (load) begin
            beat_valid <= 1'b1;
        end else if (beat_ready) begin
            beat_valid <= 1'b0;
        end
    end

    // Payload only changes on a load, so it holds under a stall
    always_ff @(posedge clk) begin
        if (load) begin
            beat <= beat_next;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cc_frame_top.sv ====
// Top level of the correlation frame builder; connect the sample source, the FFT config and data ports
`default_nettype none

module cc_frame_top import cc_stream_pkg::*, cc_ctrl_pkg::*; #(
    parameter pad_mode_t PAD = PAD_BACK
) (
    input  logic                clk,
    input  logic                reset_b,

    // Sample input stream
    input  logic                in_valid,
    output logic                in_ready,
    input  sample_t             in_sample,

    // Single-cycle frame request
    input  logic                start,

    // FFT configuration channel
    output logic                config_valid,
    input  logic                config_ready,
    output logic [CONFIG_W-1:0] config_data,

    // Padded frame to the FFT input port
    output logic                out_valid,
    input  logic                out_ready,
    output axis_beat_t          out_beat
);

    logic       smp_valid;
    logic       smp_ready;
    sample_t    smp;

    logic       beat_valid;
    logic       beat_ready;
    axis_beat_t beat;

    logic       config_done;

    stream_fifo #(
        .payload_t (sample_t),
        .DEPTH     (IN_FIFO_DEPTH)
    ) in_fifo (
        .clk       (clk),
        .reset_b   (reset_b),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_sample),
        .out_valid (smp_valid),
        .out_ready (smp_ready),
        .out_data  (smp)
    );

    fft_config_ctrl config_ctrl (
        .clk          (clk),
        .reset_b      (reset_b),
        .config_valid (config_valid),
        .config_ready (config_ready),
        .config_data  (config_data),
        .config_done  (config_done)
    );

    cc_block_controller #(
        .PAD (PAD)
    ) block_ctrl (
        .clk         (clk),
        .reset_b     (reset_b),
        .start       (start),
        .config_done (config_done),
        .smp_valid   (smp_valid),
        .smp_ready   (smp_ready),
        .smp         (smp),
        .beat_valid  (beat_valid),
        .beat_ready  (beat_ready),
        .beat        (beat)
    );

    stream_fifo #(
        .payload_t (axis_beat_t),
        .DEPTH     (OUT_FIFO_DEPTH)
    ) out_fifo (
        .clk       (clk),
        .reset_b   (reset_b),
        .in_valid  (beat_valid),
        .in_ready  (beat_ready),
        .in_data   (beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_beat)
    );

endmodule

`default_nettype wire

// ==== tests/cc_frame_top_sva.sv ====
// Handshake assertions for the frame builder top level, attached to every instance by bind
`default_nettype none

module cc_frame_top_sva import cc_stream_pkg::*, cc_ctrl_pkg::*; (
    input logic                clk,
    input logic                reset_b,
    input logic                config_valid,
    input logic                config_ready,
    input logic [CONFIG_W-1:0] config_data,
    input logic                out_valid,
    input logic                out_ready,
    input axis_beat_t          out_beat,
    input logic                smp_valid,
    input cc_state_t           ctrl_state
);
    timeunit 1ns;
    timeprecision 100ps;

    // Set once the configuration word has been taken
    logic cfg_sent;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            cfg_sent <= 1'b0;
        end else if (config_valid && config_ready) begin
            cfg_sent <= 1'b1;
        end
    end

    // Output beat held under a stall
    assert property (@(posedge clk) disable iff (!reset_b)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else $error("out_valid dropped or out_beat changed while out_ready was low");

    // Configuration word held under a stall
    assert property (@(posedge clk) disable iff (!reset_b)
        config_valid && !config_ready |=> config_valid && $stable(config_data))
        else $error("config_valid dropped or config_data changed while config_ready was low");

    assert property (@(posedge clk) disable iff (!reset_b)
        cfg_sent |-> !config_valid)
        else $error("config_valid rose again after the configuration transfer");

    // Nothing to send when idle with both buffers empty
    assert property (@(posedge clk) disable iff (!reset_b)
        (ctrl_state == IDLE) && !smp_valid && !out_valid |=> !out_valid)
        else $error("out_valid rose while the controller was idle and the buffers were empty");

endmodule

bind cc_frame_top cc_frame_top_sva sva_inst (
    .clk          (clk),
    .reset_b      (reset_b),
    .config_valid (config_valid),
    .config_ready (config_ready),
    .config_data  (config_data),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_beat     (out_beat),
    .smp_valid    (smp_valid),
    .ctrl_state   (block_ctrl.state)
);

`default_nettype wire

// ==== tests/tb_cc_frame_top.sv ====
// Table-driven testbench for the frame builder; simulate with tb_cc_frame_top as the top module
`default_nettype none

module tb_cc_frame_top import cc_stream_pkg::*, cc_ctrl_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam pad_mode_t PAD = PAD_BACK;
    localparam int NUM_ROWS = 6;

    // One row per frame
    typedef struct packed {
        int idle_cycles;
        int out_ready_pct;
        int in_valid_pct;
        int cfg_delay;
    } row_t;

    // Row 0 requests its frame before the configuration transfer
    localparam row_t ROWS [NUM_ROWS] = '{
        '{2, 100, 100, 12},
        '{0, 100, 100, 0},
        '{5, 50, 100, 3},
        '{3, 30, 70, 0},
        '{10, 80, 40, 5},
        '{1, 40, 30, 2}
    };

    // Generous bound for the slowest rates in the table
    localparam int WORST_FRAME_CYCLES = 32 + 2 * FRAME_LEN * 25;
    localparam int SETUP_CYCLES       = 16 + 2 * IN_FIFO_DEPTH;
    localparam int CYCLE_LIMIT        = SETUP_CYCLES + NUM_ROWS * WORST_FRAME_CYCLES;

    logic                clk;
    logic                reset_b;
    logic                in_valid;
    logic                in_ready;
    sample_t             in_sample;
    logic                start;
    logic                config_valid;
    logic                config_ready;
    logic [CONFIG_W-1:0] config_data;
    logic                out_valid;
    logic                out_ready;
    axis_beat_t          out_beat;

    // Reference model state
    sample_t             ref_q [$];
    int                  in_pct;
    int                  out_pct;
    bit                  src_on;
    bit                  in_taken;
    bit                  config_seen;
    int                  frames_done;
    int                  starts_issued;
    int                  beat_idx;
    int                  cycle_cnt;
    logic [SAMPLE_W-1:0] sample_base;
    int unsigned         sample_num;

    cc_frame_top #(
        .PAD (PAD)
    ) cc_frame_top_inst (.*);

    always #20 clk = ~clk;

    task automatic stop_run();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic compare(string name, logic [63:0] actual, logic [63:0] expected);
        if (actual !== expected) begin
            $display("Error at %0d ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            stop_run();
        end
    endtask

    task automatic fail_with(string what);
        $display("Error at %0d ns: %s", $time, what);
        stop_run();
    endtask

    // Expected beat follows the padding rule and the order of accepted samples
    task automatic check_out_beat();
        sample_t             exp_smp;
        logic [SAMPLE_W-1:0] exp_data;
        bit                  is_data;
        is_data  = (PAD == PAD_BACK) ? (beat_idx < FRAME_LEN) : (beat_idx >= FRAME_LEN);
        exp_data = '0;
        if (is_data) begin
            if (ref_q.size() == 0) begin
                fail_with("a data beat came out but no accepted sample was left");
            end else begin
                exp_smp  = ref_q.pop_front();
                exp_data = exp_smp.data;
            end
        end
        compare("out_beat.data", out_beat.data, exp_data);
        compare("out_beat.last", out_beat.last, beat_idx == 2 * FRAME_LEN - 1);
        beat_idx++;
        if (beat_idx == 2 * FRAME_LEN) begin
            beat_idx = 0;
            frames_done++;
        end
    endtask

    task automatic release_config_after(int delay);
        repeat (delay) @(posedge clk);
        config_ready <= 1'b1;
    endtask

    task automatic issue_start(int idle);
        repeat (idle) @(posedge clk);
        start <= 1'b1;
        starts_issued++;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // Sample source, a new sample only once the previous one is taken
    always @(posedge clk) begin
        if (!in_valid || in_taken) begin
            if (src_on && ($urandom_range(99) < in_pct)) begin
                in_valid       <= 1'b1;
                in_sample.data <= sample_base + sample_num;
                sample_num++;
            end else begin
                in_valid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        out_ready <= ($urandom_range(99) < out_pct);
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            stop_run();
        end
    end

    // Monitor between edges, where every signal is settled
    always @(negedge clk) begin
        if (!reset_b) begin
            // Flops hold their reset value once the first edge has passed
            if (cycle_cnt > 0) begin
                compare("config_valid", config_valid, 1'b0);
            end
            in_taken = 1'b0;
        end else begin
            in_taken = in_valid && in_ready;
            if (config_seen) begin
                compare("config_valid", config_valid, 1'b0);
            end
            if (config_valid) begin
                compare("config_data", config_data, CONFIG_WORD);
                if (config_ready) begin
                    config_seen = 1'b1;
                end
            end
            if (out_valid && !config_seen) begin
                fail_with("an output beat appeared before the configuration transfer");
            end
            if (out_valid && (frames_done >= starts_issued)) begin
                fail_with("an output beat appeared with no frame requested");
            end
            if (out_valid && out_ready) begin
                check_out_beat();
            end
            if (in_taken) begin
                ref_q.push_back(in_sample);
            end
        end
    end

    initial begin
        void'($urandom(32'h49a9));
        clk           = 1'b0;
        reset_b       = 1'b0;
        in_valid      = 1'b0;
        in_sample     = '0;
        start         = 1'b0;
        config_ready  = 1'b0;
        out_ready     = 1'b0;
        src_on        = 1'b0;
        in_pct        = 0;
        out_pct       = 0;
        in_taken      = 1'b0;
        config_seen   = 1'b0;
        frames_done   = 0;
        starts_issued = 0;
        beat_idx      = 0;
        cycle_cnt     = 0;
        sample_num    = 0;
        sample_base   = $urandom();

        repeat (4) @(posedge clk);
        reset_b <= 1'b1;

        // config_valid is registered one edge after reset leaves
        @(posedge clk);
        @(negedge clk);
        compare("config_valid", config_valid, 1'b1);

        // Without a start the input FIFO fills and then holds in_ready low
        src_on = 1'b1;
        in_pct = 100;
        repeat (IN_FIFO_DEPTH + 4) @(posedge clk);
        repeat (4) begin
            @(negedge clk);
            compare("in_ready", in_ready, 1'b0);
        end
        compare("accepted samples", ref_q.size(), IN_FIFO_DEPTH);
        compare("out_valid", out_valid, 1'b0);

        @(posedge clk);
        for (int r = 0; r < NUM_ROWS; r++) begin
            in_pct  = ROWS[r].in_valid_pct;
            out_pct = ROWS[r].out_ready_pct;
            config_ready <= 1'b0;
            fork
                release_config_after(ROWS[r].cfg_delay);
                issue_start(ROWS[r].idle_cycles);
            join
            while (frames_done < r + 1) begin
                @(posedge clk);
            end
        end

        repeat (4) @(posedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/cc_stream_pkg.sv
verilog/cc_ctrl_pkg.sv
verilog/stream_fifo.sv
verilog/fft_config_ctrl.sv
verilog/cc_block_controller.sv
verilog/cc_frame_top.sv
tests/cc_frame_top_sva.sv
tests/tb_cc_frame_top.sv
